/* rtl/mmu_cfg_pkg.sv */
/*
 * MMU configuration: page number and ASID widths,
 * privilege mode and access type encodings
 */
package mmu_cfg_pkg;

  // ==================================================
  // Widths
  // ==================================================
  localparam int VPN_W  = 20;
  localparam int PPN_W  = 22;
  localparam int ASID_W = 9;

  // ==================================================
  // Encodings
  // ==================================================
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } priv_mode_e;

  typedef enum logic [1:0] {
    ACC_FETCH = 2'b00,
    ACC_LOAD  = 2'b01,
    ACC_STORE = 2'b10
  } acc_type_e;

endpackage

/* rtl/mmu_xlat_pkg.sv */
/*
 * Translation traffic: requester request and response,
 * refill request and response, joint TLB write port,
 * page flags and the refill FSM states
 */
package mmu_xlat_pkg;
  import mmu_cfg_pkg::*;

  // Page flags as held in both TLB levels
  typedef struct packed {
    logic v;
    logic r;
    logic w;
    logic x;
    logic u;
  } pte_flg_t;

  // Requester side
  typedef struct packed {
    logic [VPN_W-1:0] vpn;
    priv_mode_e       priv;
    logic             store;
  } xlat_req_t;

  typedef struct packed {
    logic             pa_vld;
    logic [PPN_W-1:0] ppn;
    logic             page_fault;
  } xlat_rsp_t;

  // Micro-TLB to joint TLB
  typedef struct packed {
    logic [VPN_W-1:0]  vpn;
    logic [ASID_W-1:0] asid;
  } ref_req_t;

  typedef struct packed {
    logic              cmplt;
    logic              hit;
    logic [PPN_W-1:0]  ppn;
    logic [ASID_W-1:0] asid;
    logic              g;
    pte_flg_t          flg;
  } ref_rsp_t;

  // Software load of the joint TLB
  typedef struct packed {
    logic              wen;
    logic [VPN_W-1:0]  vpn;
    logic [PPN_W-1:0]  ppn;
    logic [ASID_W-1:0] asid;
    logic              g;
    pte_flg_t          flg;
  } jtlb_wr_t;

  typedef enum logic [1:0] {
    RF_IDLE = 2'b00,
    RF_REQ  = 2'b01,
    RF_WAIT = 2'b10
  } refill_st_e;

endpackage

/* rtl/mmu_utlb.sv */
/*
 * Micro-TLB: fully associative entries, permission check,
 * refill FSM toward the joint TLB, miss pulse
 */
`timescale 1ns/1ps

module mmu_utlb #(
  parameter int UTLB_ENTRIES = 4,
  parameter bit FETCH_SIDE   = 1'b0
) (
  input  logic                           forever_cpuclk,
  input  logic                           rst_n,
  input  logic                           va_vld,
  input  mmu_xlat_pkg::xlat_req_t        xreq,
  input  logic                           abort,
  input  logic                           mmu_en,
  input  logic [mmu_cfg_pkg::ASID_W-1:0] cur_asid,
  input  logic                           tlb_clr,
  input  logic                           grant,
  input  mmu_xlat_pkg::ref_rsp_t         ref_rsp,
  output mmu_xlat_pkg::xlat_rsp_t        xrsp,
  output logic                           ref_req_vld,
  output mmu_xlat_pkg::ref_req_t         ref_req,
  output logic                           utlb_miss
);
  import mmu_cfg_pkg::*;
  import mmu_xlat_pkg::*;

  localparam int IDX_W = (UTLB_ENTRIES > 1) ? $clog2(UTLB_ENTRIES) : 1;

  typedef struct packed {
    logic [VPN_W-1:0]  vpn;
    logic [PPN_W-1:0]  ppn;
    logic [ASID_W-1:0] asid;
    logic              g;
    pte_flg_t          flg;
  } utlb_ent_t;

  utlb_ent_t               ent [UTLB_ENTRIES];
  logic [UTLB_ENTRIES-1:0] ent_vld;
  logic [IDX_W-1:0]        rr_ptr;

  refill_st_e       ref_st;
  logic [VPN_W-1:0] ref_vpn;
  logic             abort_q;

  logic             rsp_vld;
  logic [PPN_W-1:0] rsp_ppn;
  logic             rsp_pf;

  acc_type_e acc;
  logic      bypass;
  logic      lkup_hit;
  utlb_ent_t lkup_ent;
  logic      req_new;
  logic      miss_det;
  logic      ref_done;
  logic      fill_ok;

  // R/W/X by access type, U bit by privilege
  function automatic logic perm_ok(pte_flg_t flg, priv_mode_e priv, acc_type_e at);
    logic rwx_ok;
    case (at)
      ACC_FETCH: rwx_ok = flg.x;
      ACC_LOAD:  rwx_ok = flg.r;
      default:   rwx_ok = flg.w;
    endcase
    return rwx_ok && ((priv == PRIV_U) ? flg.u : !flg.u);
  endfunction

  // ==================================================
  // Lookup
  // ==================================================
  always_comb begin
    if (FETCH_SIDE)
      acc = ACC_FETCH;
    else if (xreq.store)
      acc = ACC_STORE;
    else
      acc = ACC_LOAD;
  end

  assign bypass = !mmu_en || (xreq.priv == PRIV_M);

  // Held request is not taken again while its answer is out
  assign req_new  = va_vld && !abort && !rsp_vld && (ref_st == RF_IDLE);
  assign miss_det = req_new && !bypass && !lkup_hit;
  assign ref_done = (ref_st == RF_WAIT) && ref_rsp.cmplt;
  assign fill_ok  = ref_rsp.hit && ref_rsp.flg.v;

  always_comb begin
    lkup_hit = 1'b0;
    lkup_ent = '0;
    for (int i = 0; i < UTLB_ENTRIES; i++) begin
      if (!lkup_hit && ent_vld[i] && (ent[i].vpn == xreq.vpn) &&
          (ent[i].g || (ent[i].asid == cur_asid))) begin
        lkup_hit = 1'b1;
        lkup_ent = ent[i];
      end
    end
  end

  // ==================================================
  // Refill FSM
  // ==================================================
  always_ff @(posedge forever_cpuclk or negedge rst_n) begin
    if (!rst_n) begin
      ref_st    <= RF_IDLE;
      abort_q   <= 1'b0;
      utlb_miss <= 1'b0;
    end else begin
      utlb_miss <= miss_det;
      case (ref_st)
        RF_IDLE: begin
          if (miss_det) begin
            ref_st  <= RF_REQ;
            abort_q <= 1'b0;
          end
        end
        RF_REQ:  if (grant) ref_st <= RF_WAIT;
        RF_WAIT: if (ref_rsp.cmplt) ref_st <= RF_IDLE;
        default: ref_st <= RF_IDLE;
      endcase
      // Withdrawn request still finishes its refill
      if ((ref_st != RF_IDLE) && abort)
        abort_q <= 1'b1;
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (miss_det)
      ref_vpn <= xreq.vpn;
  end

  assign ref_req_vld  = (ref_st == RF_REQ);
  assign ref_req.vpn  = ref_vpn;
  assign ref_req.asid = cur_asid;

  // ==================================================
  // Entries filled round robin
  // ==================================================
  always_ff @(posedge forever_cpuclk or negedge rst_n) begin
    if (!rst_n) begin
      ent_vld <= '0;
      rr_ptr  <= '0;
    end else if (tlb_clr) begin
      ent_vld <= '0;
    end else if (ref_done && fill_ok) begin
      ent_vld[rr_ptr] <= 1'b1;
      rr_ptr <= (rr_ptr == IDX_W'(UTLB_ENTRIES - 1)) ? '0 : rr_ptr + 1'b1;
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (ref_done && fill_ok)
      ent[rr_ptr] <= '{vpn: ref_vpn, ppn: ref_rsp.ppn, asid: ref_rsp.asid,
                       g: ref_rsp.g, flg: ref_rsp.flg};
  end

  // ==================================================
  // Response
  // ==================================================
  always_ff @(posedge forever_cpuclk or negedge rst_n) begin
    if (!rst_n)
      rsp_vld <= 1'b0;
    else
      rsp_vld <= (req_new && (bypass || lkup_hit)) || (ref_done && !abort_q && !abort);
  end

  always_ff @(posedge forever_cpuclk) begin
    if (req_new && bypass) begin
      rsp_ppn <= PPN_W'(xreq.vpn);
      rsp_pf  <= 1'b0;
    end else if (req_new && lkup_hit) begin
      rsp_ppn <= lkup_ent.ppn;
      rsp_pf  <= !perm_ok(lkup_ent.flg, xreq.priv, acc);
    end else if (ref_done) begin
      rsp_ppn <= ref_rsp.ppn;
      rsp_pf  <= !(fill_ok && perm_ok(ref_rsp.flg, xreq.priv, acc));
    end
  end

  assign xrsp.pa_vld     = rsp_vld;
  assign xrsp.ppn        = rsp_ppn;
  assign xrsp.page_fault = rsp_pf;

  // Arbiter grants only a pending refill
  a_grant_in_req: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    grant |-> (ref_st == RF_REQ));

  // Answer only for a request still held
  a_pavld_live: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    rsp_vld |-> $past(va_vld && !abort));

  // Completion is routed only to the owner
  a_cmplt_in_wait: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    ref_rsp.cmplt |-> (ref_st == RF_WAIT));

endmodule

/* rtl/mmu_utlb_arb.sv */
/*
 * Fixed-priority arbiter of the two micro-TLBs onto the
 * joint TLB, data side first, one refill at a time
 */
`timescale 1ns/1ps

module mmu_utlb_arb (
  input  logic                   forever_cpuclk,
  input  logic                   rst_n,
  input  logic                   iutlb_req_vld,
  input  mmu_xlat_pkg::ref_req_t iutlb_req,
  input  logic                   dutlb_req_vld,
  input  mmu_xlat_pkg::ref_req_t dutlb_req,
  input  mmu_xlat_pkg::ref_rsp_t jtlb_rsp,
  output logic                   iutlb_grant,
  output logic                   dutlb_grant,
  output logic                   jtlb_lookup,
  output mmu_xlat_pkg::ref_req_t jtlb_req,
  output mmu_xlat_pkg::ref_rsp_t iutlb_rsp,
  output mmu_xlat_pkg::ref_rsp_t dutlb_rsp
);
  import mmu_xlat_pkg::*;

  logic busy;
  // Set when the data side owns the refill
  logic own_d;

  assign dutlb_grant = !busy && dutlb_req_vld;
  assign iutlb_grant = !busy && iutlb_req_vld && !dutlb_req_vld;
  assign jtlb_lookup = dutlb_grant || iutlb_grant;
  assign jtlb_req    = dutlb_grant ? dutlb_req : iutlb_req;

  always_ff @(posedge forever_cpuclk or negedge rst_n) begin
    if (!rst_n) begin
      busy  <= 1'b0;
      own_d <= 1'b0;
    end else if (jtlb_lookup) begin
      busy  <= 1'b1;
      own_d <= dutlb_grant;
    end else if (jtlb_rsp.cmplt) begin
      busy  <= 1'b0;
    end
  end

  // Payload goes to both sides, completion to the owner only
  always_comb begin
    iutlb_rsp       = jtlb_rsp;
    dutlb_rsp       = jtlb_rsp;
    iutlb_rsp.cmplt = jtlb_rsp.cmplt && busy && !own_d;
    dutlb_rsp.cmplt = jtlb_rsp.cmplt && busy && own_d;
  end

  // Joint TLB answers two cycles after the lookup
  a_cmplt_timing: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    jtlb_rsp.cmplt |-> $past(jtlb_lookup, 2));

  a_no_idle_cmplt: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    jtlb_rsp.cmplt |-> busy);

endmodule

/* rtl/mmu_jtlb.sv */
/*
 * Joint TLB: direct-mapped table loaded by software,
 * two-cycle lookup pipeline
 */
`timescale 1ns/1ps

module mmu_jtlb #(
  parameter int JTLB_ENTRIES = 16
) (
  input  logic                   forever_cpuclk,
  input  logic                   rst_n,
  input  mmu_xlat_pkg::jtlb_wr_t wr,
  input  logic                   lookup,
  input  mmu_xlat_pkg::ref_req_t req,
  output mmu_xlat_pkg::ref_rsp_t rsp
);
  import mmu_cfg_pkg::*;
  import mmu_xlat_pkg::*;

  localparam int IDX_W = $clog2(JTLB_ENTRIES);
  localparam int TAG_W = VPN_W - IDX_W;

  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [PPN_W-1:0]  ppn;
    logic [ASID_W-1:0] asid;
    logic              g;
    pte_flg_t          flg;
  } jtlb_ent_t;

  jtlb_ent_t               ent [JTLB_ENTRIES];
  logic [JTLB_ENTRIES-1:0] ent_vld;
  logic [IDX_W-1:0]        wr_idx;

  // Stage one holds the request
  logic             s1_vld;
  ref_req_t         s1_req;
  logic [IDX_W-1:0] s1_idx;
  jtlb_ent_t        s1_ent;
  logic             s1_hit;

  // Stage two holds the result
  logic              rsp_cmplt;
  logic              rsp_hit;
  logic [PPN_W-1:0]  rsp_ppn;
  logic [ASID_W-1:0] rsp_asid;
  logic              rsp_g;
  pte_flg_t          rsp_flg;

  assign wr_idx = wr.vpn[IDX_W-1:0];
  assign s1_idx = s1_req.vpn[IDX_W-1:0];
  assign s1_ent = ent[s1_idx];
  assign s1_hit = ent_vld[s1_idx] && (s1_ent.tag == s1_req.vpn[VPN_W-1:IDX_W]) &&
                  (s1_ent.g || (s1_ent.asid == s1_req.asid));

  always_ff @(posedge forever_cpuclk or negedge rst_n) begin
    if (!rst_n) begin
      ent_vld   <= '0;
      s1_vld    <= 1'b0;
      rsp_cmplt <= 1'b0;
    end else begin
      s1_vld    <= lookup;
      rsp_cmplt <= s1_vld;
      if (wr.wen)
        ent_vld[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (wr.wen)
      ent[wr_idx] <= '{tag: wr.vpn[VPN_W-1:IDX_W], ppn: wr.ppn, asid: wr.asid,
                       g: wr.g, flg: wr.flg};
    if (lookup)
      s1_req <= req;
    if (s1_vld) begin
      rsp_hit  <= s1_hit;
      rsp_ppn  <= s1_ent.ppn;
      rsp_asid <= s1_ent.asid;
      rsp_g    <= s1_ent.g;
      rsp_flg  <= s1_ent.flg;
    end
  end

  assign rsp = '{cmplt: rsp_cmplt, hit: rsp_hit, ppn: rsp_ppn, asid: rsp_asid,
                 g: rsp_g, flg: rsp_flg};

endmodule

/* rtl/mmu_utlb_top.sv */
/*
 * Micro-TLB layer: instruction and data micro-TLBs,
 * refill arbiter and joint TLB
 */
`timescale 1ns/1ps

module mmu_utlb_top #(
  parameter int UTLB_ENTRIES = 4,
  parameter int JTLB_ENTRIES = 16
) (
  input  logic                           forever_cpuclk,
  input  logic                           rst_n,
  input  logic                           ifu_va_vld,
  input  mmu_xlat_pkg::xlat_req_t        ifu_req,
  input  logic                           ifu_abort,
  input  logic                           lsu_va_vld,
  input  mmu_xlat_pkg::xlat_req_t        lsu_req,
  input  logic                           lsu_abort,
  input  logic                           mmu_en,
  input  logic [mmu_cfg_pkg::ASID_W-1:0] cur_asid,
  input  logic                           tlb_clr,
  input  mmu_xlat_pkg::jtlb_wr_t         jtlb_wr,
  output mmu_xlat_pkg::xlat_rsp_t        ifu_rsp,
  output mmu_xlat_pkg::xlat_rsp_t        lsu_rsp,
  output logic                           iutlb_miss,
  output logic                           dutlb_miss
);
  import mmu_xlat_pkg::*;

  logic     iutlb_req_vld;
  logic     dutlb_req_vld;
  logic     iutlb_grant;
  logic     dutlb_grant;
  logic     jtlb_lookup;
  ref_req_t iutlb_req;
  ref_req_t dutlb_req;
  ref_req_t jtlb_req;
  ref_rsp_t iutlb_rsp;
  ref_rsp_t dutlb_rsp;
  ref_rsp_t jtlb_rsp;

  // ==================================================
  // Micro-TLBs
  // ==================================================
  mmu_utlb #(.UTLB_ENTRIES(UTLB_ENTRIES), .FETCH_SIDE(1'b1)) u_iutlb (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .va_vld         (ifu_va_vld),
    .xreq           (ifu_req),
    .abort          (ifu_abort),
    .mmu_en         (mmu_en),
    .cur_asid       (cur_asid),
    .tlb_clr        (tlb_clr),
    .grant          (iutlb_grant),
    .ref_rsp        (iutlb_rsp),
    .xrsp           (ifu_rsp),
    .ref_req_vld    (iutlb_req_vld),
    .ref_req        (iutlb_req),
    .utlb_miss      (iutlb_miss)
  );

  mmu_utlb #(.UTLB_ENTRIES(UTLB_ENTRIES), .FETCH_SIDE(1'b0)) u_dutlb (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .va_vld         (lsu_va_vld),
    .xreq           (lsu_req),
    .abort          (lsu_abort),
    .mmu_en         (mmu_en),
    .cur_asid       (cur_asid),
    .tlb_clr        (tlb_clr),
    .grant          (dutlb_grant),
    .ref_rsp        (dutlb_rsp),
    .xrsp           (lsu_rsp),
    .ref_req_vld    (dutlb_req_vld),
    .ref_req        (dutlb_req),
    .utlb_miss      (dutlb_miss)
  );

  // ==================================================
  // Shared refill path
  // ==================================================
  mmu_utlb_arb u_arb (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .iutlb_req_vld  (iutlb_req_vld),
    .iutlb_req      (iutlb_req),
    .dutlb_req_vld  (dutlb_req_vld),
    .dutlb_req      (dutlb_req),
    .jtlb_rsp       (jtlb_rsp),
    .iutlb_grant    (iutlb_grant),
    .dutlb_grant    (dutlb_grant),
    .jtlb_lookup    (jtlb_lookup),
    .jtlb_req       (jtlb_req),
    .iutlb_rsp      (iutlb_rsp),
    .dutlb_rsp      (dutlb_rsp)
  );

  mmu_jtlb #(.JTLB_ENTRIES(JTLB_ENTRIES)) u_jtlb (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .wr             (jtlb_wr),
    .lookup         (jtlb_lookup),
    .req            (jtlb_req),
    .rsp            (jtlb_rsp)
  );

endmodule

/* bench/tb_mmu_utlb_top.sv */
/*
 * Testbench for the micro-TLB layer: clock, reset, seeded
 * random stimulus, reference model of both TLB levels, checks
 */
`timescale 1ns/1ps

module tb_mmu_utlb_top;
  import mmu_cfg_pkg::*;
  import mmu_xlat_pkg::*;

  localparam int UTLB_N    = 4;
  localparam int JTLB_N    = 16;
  localparam int IDX_W     = $clog2(JTLB_N);
  localparam int SIDE_I    = 0;
  localparam int SIDE_D    = 1;
  localparam int N_BYP     = 8;
  localparam int N_RAND    = 60;
  localparam int N_CONT    = 40;
  // A refill may queue behind one refill of the other side
  localparam int WORST_LAT = 16;
  localparam int N_REQ     = 4 * N_BYP + 4 * UTLB_N + N_RAND + 2 * N_CONT + 16;
  localparam int CYCLE_LIMIT = 16 + 4 * (JTLB_N + 2) + N_REQ * (WORST_LAT + 2) + 64;

  logic              forever_cpuclk;
  logic              rst_n;
  logic              ifu_va_vld;
  xlat_req_t         ifu_req;
  logic              ifu_abort;
  logic              lsu_va_vld;
  xlat_req_t         lsu_req;
  logic              lsu_abort;
  logic              mmu_en;
  logic [ASID_W-1:0] cur_asid;
  logic              tlb_clr;
  jtlb_wr_t          jtlb_wr;
  xlat_rsp_t         ifu_rsp;
  xlat_rsp_t         lsu_rsp;
  logic              iutlb_miss;
  logic              dutlb_miss;

  // Model copies of both levels
  // An entry with wen set is valid
  jtlb_wr_t jm [JTLB_N];
  jtlb_wr_t um [2][UTLB_N];
  int       um_ptr [2];

  integer seed;
  int     checks;
  int     errors;
  int     cycles;

  mmu_utlb_top #(.UTLB_ENTRIES(UTLB_N), .JTLB_ENTRIES(JTLB_N)) u_mmu_utlb_top (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .ifu_va_vld     (ifu_va_vld),
    .ifu_req        (ifu_req),
    .ifu_abort      (ifu_abort),
    .lsu_va_vld     (lsu_va_vld),
    .lsu_req        (lsu_req),
    .lsu_abort      (lsu_abort),
    .mmu_en         (mmu_en),
    .cur_asid       (cur_asid),
    .tlb_clr        (tlb_clr),
    .jtlb_wr        (jtlb_wr),
    .ifu_rsp        (ifu_rsp),
    .lsu_rsp        (lsu_rsp),
    .iutlb_miss     (iutlb_miss),
    .dutlb_miss     (dutlb_miss)
  );

  initial begin
    forever_cpuclk = 1'b0;
    forever #5 forever_cpuclk = ~forever_cpuclk;
  end

  // Watchdog on the whole run
  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge forever_cpuclk);
      cycles++;
    end
    $display("Run stopped at the cycle limit of %0d before all tests ended", CYCLE_LIMIT);
    $display("Finished with errors");
    $finish;
  end

  // ==================================================
  // Reference rules
  // ==================================================
  function automatic int rand_below(int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  function automatic logic access_ok(pte_flg_t f, priv_mode_e p, logic fetch, logic store);
    logic rwx;
    rwx = fetch ? f.x : (store ? f.w : f.r);
    if (p == PRIV_U)
      return rwx && f.u;
    return rwx && !f.u;
  endfunction

  function automatic logic page_match(jtlb_wr_t e, logic [VPN_W-1:0] vpn);
    return e.wen && (e.vpn == vpn) && (e.g || (e.asid == cur_asid));
  endfunction

  function automatic int utlb_slot(int side, logic [VPN_W-1:0] vpn);
    for (int i = 0; i < UTLB_N; i++)
      if (page_match(um[side][i], vpn))
        return i;
    return -1;
  endfunction

  // Refill writes only a present page with its valid flag set
  function automatic void fill_model(int side, logic [VPN_W-1:0] vpn);
    jtlb_wr_t e;
    e = jm[vpn[IDX_W-1:0]];
    if (page_match(e, vpn) && e.flg.v) begin
      um[side][um_ptr[side]] = e;
      um_ptr[side] = (um_ptr[side] + 1) % UTLB_N;
    end
  endfunction

  task automatic check_val(string tname, string what, logic [31:0] exp, logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("Fail %s %s: expected %0h, actual %0h", tname, what, exp, act);
    end
  endtask

  // ==================================================
  // Stimulus
  // ==================================================
  task automatic drive_req(int side, logic vld, xlat_req_t req, logic abt);
    if (side == SIDE_D) begin
      lsu_va_vld <= vld;
      lsu_req    <= req;
      lsu_abort  <= abt;
    end else begin
      ifu_va_vld <= vld;
      ifu_req    <= req;
      ifu_abort  <= abt;
    end
  endtask

  task automatic translate(int side, logic [VPN_W-1:0] vpn, priv_mode_e priv, logic store,
                           string tname);
    xlat_req_t        req;
    xlat_rsp_t        rsp;
    jtlb_wr_t         e;
    logic             byp;
    logic             exp_miss;
    logic             exp_pf;
    logic [PPN_W-1:0] exp_ppn;
    int               n;
    int               misses;
    req = '{vpn: vpn, priv: priv, store: store};
    @(posedge forever_cpuclk);
    e        = jm[vpn[IDX_W-1:0]];
    byp      = !mmu_en || (priv == PRIV_M);
    exp_miss = !byp && (utlb_slot(side, vpn) < 0);
    exp_pf   = !byp && !(page_match(e, vpn) && e.flg.v &&
                          access_ok(e.flg, priv, side == SIDE_I, store));
    exp_ppn  = byp ? PPN_W'(vpn) : e.ppn;
    drive_req(side, 1'b1, req, 1'b0);
    // Edge that takes the request
    @(posedge forever_cpuclk);
    n = 0;
    misses = 0;
    do begin
      @(negedge forever_cpuclk);
      n++;
      rsp = (side == SIDE_D) ? lsu_rsp : ifu_rsp;
      if ((side == SIDE_D) ? dutlb_miss : iutlb_miss)
        misses++;
    end while (!rsp.pa_vld && n < WORST_LAT);
    @(posedge forever_cpuclk);
    drive_req(side, 1'b0, req, 1'b0);
    checks++;
    assert (rsp.pa_vld) else begin
      errors++;
      $display("%s: no response on side %0d within %0d cycles", tname, side, WORST_LAT);
    end
    check_val(tname, "page_fault", 32'(exp_pf), 32'(rsp.page_fault));
    if (!exp_pf)
      check_val(tname, "ppn", 32'(exp_ppn), 32'(rsp.ppn));
    check_val(tname, "miss pulses", 32'(exp_miss), 32'(misses));
    // Hit and bypass answer in the cycle after the taking edge
    if (!exp_miss)
      check_val(tname, "latency", 32'd1, 32'(n));
    else
      fill_model(side, vpn);
  endtask

  task automatic random_req(int side, string tname);
    logic [VPN_W-1:0] vpn;
    priv_mode_e       p;
    logic             st;
    vpn = VPN_W'(rand_below(3) * JTLB_N + rand_below(6));
    p   = (rand_below(8) == 0) ? PRIV_M : ((rand_below(2) == 0) ? PRIV_U : PRIV_S);
    st  = (rand_below(2) == 1);
    translate(side, vpn, p, st, tname);
  endtask

  task automatic abort_req(int side, logic [VPN_W-1:0] vpn, string tname);
    xlat_req_t req;
    xlat_rsp_t rsp;
    logic      miss_now;
    req = '{vpn: vpn, priv: PRIV_U, store: 1'b0};
    @(posedge forever_cpuclk);
    drive_req(side, 1'b1, req, 1'b0);
    @(posedge forever_cpuclk);
    @(negedge forever_cpuclk);
    miss_now = (side == SIDE_D) ? dutlb_miss : iutlb_miss;
    check_val(tname, "miss pulses", 32'd1, 32'(miss_now));
    @(posedge forever_cpuclk);
    drive_req(side, 1'b0, req, 1'b1);
    @(posedge forever_cpuclk);
    drive_req(side, 1'b0, req, 1'b0);
    for (int k = 0; k < WORST_LAT; k++) begin
      @(negedge forever_cpuclk);
      rsp = (side == SIDE_D) ? lsu_rsp : ifu_rsp;
      checks++;
      assert (!rsp.pa_vld) else begin
        errors++;
        $display("%s: pa_vld rose on side %0d after the request was aborted", tname, side);
      end
    end
    // Refill still lands in the micro-TLB
    fill_model(side, vpn);
  endtask

  task automatic write_entry(jtlb_wr_t w);
    @(posedge forever_cpuclk);
    jtlb_wr <= w;
    jm[w.vpn[IDX_W-1:0]] = w;
  endtask

  task automatic clear_tlbs();
    @(posedge forever_cpuclk);
    jtlb_wr.wen <= 1'b0;
    tlb_clr     <= 1'b1;
    @(posedge forever_cpuclk);
    tlb_clr     <= 1'b0;
    for (int s = 0; s < 2; s++)
      for (int i = 0; i < UTLB_N; i++)
        um[s][i].wen = 1'b0;
  endtask

  task automatic load_random_jtlb();
    jtlb_wr_t w;
    for (int i = 0; i < JTLB_N; i++) begin
      w.wen   = 1'b1;
      w.vpn   = VPN_W'(rand_below(2) * JTLB_N + i);
      w.ppn   = PPN_W'(rand_below(1 << PPN_W));
      w.asid  = (rand_below(4) == 0) ? ASID_W'(rand_below(1 << ASID_W)) : cur_asid;
      w.g     = (rand_below(4) == 0);
      w.flg   = pte_flg_t'(5'(rand_below(32)));
      w.flg.v = (rand_below(8) != 0);
      write_entry(w);
    end
    clear_tlbs();
  endtask

  // Full permissions for the low pages
  task automatic load_directed_jtlb();
    jtlb_wr_t w;
    for (int i = 0; i < UTLB_N; i++) begin
      w = '{wen: 1'b1, vpn: VPN_W'(i), ppn: PPN_W'(rand_below(1 << PPN_W)),
            asid: cur_asid, g: 1'b0, flg: '1};
      write_entry(w);
    end
    clear_tlbs();
  endtask

  // ==================================================
  // Test sequence
  // ==================================================
  initial begin
    seed       = 32'hf404;
    checks     = 0;
    errors     = 0;
    rst_n      = 1'b0;
    ifu_va_vld = 1'b0;
    ifu_req    = '0;
    ifu_abort  = 1'b0;
    lsu_va_vld = 1'b0;
    lsu_req    = '0;
    lsu_abort  = 1'b0;
    mmu_en     = 1'b1;
    cur_asid   = 9'h005;
    tlb_clr    = 1'b0;
    jtlb_wr    = '0;
    for (int i = 0; i < JTLB_N; i++)
      jm[i] = '0;
    for (int s = 0; s < 2; s++) begin
      um_ptr[s] = 0;
      for (int i = 0; i < UTLB_N; i++)
        um[s][i] = '0;
    end
    repeat (16) @(posedge forever_cpuclk);
    rst_n <= 1'b1;

    // Bypass by machine mode, then by mmu_en low
    for (int k = 0; k < 2 * N_BYP; k++)
      translate(k % 2, VPN_W'(rand_below(1 << VPN_W)), PRIV_M, k[1], "bypass_m");
    @(posedge forever_cpuclk);
    mmu_en <= 1'b0;
    for (int k = 0; k < 2 * N_BYP; k++)
      translate(k % 2, VPN_W'(rand_below(1 << VPN_W)), PRIV_S, k[1], "bypass_off");
    @(posedge forever_cpuclk);
    mmu_en <= 1'b1;

    // Refill then hit
    load_directed_jtlb();
    for (int pass = 0; pass < 2; pass++)
      for (int i = 0; i < UTLB_N; i++) begin
        translate(SIDE_D, VPN_W'(i), PRIV_U, 1'b0, "refill_hit");
        translate(SIDE_I, VPN_W'(i), PRIV_U, 1'b0, "refill_hit");
      end

    // Random flags, privilege and ASID
    load_random_jtlb();
    for (int k = 0; k < N_RAND; k++) begin
      if (k == N_RAND / 2) begin
        @(posedge forever_cpuclk);
        cur_asid <= 9'h00a;
      end
      random_req(k % 2, "faults");
    end

    // Both sides at once
    load_random_jtlb();
    fork
      begin
        for (int k = 0; k < N_CONT; k++)
          random_req(SIDE_I, "contention");
      end
      begin
        for (int k = 0; k < N_CONT; k++)
          random_req(SIDE_D, "contention");
      end
    join

    // Clear, then abort
    load_directed_jtlb();
    translate(SIDE_D, VPN_W'(1), PRIV_U, 1'b0, "clear");
    translate(SIDE_D, VPN_W'(1), PRIV_U, 1'b0, "clear");
    translate(SIDE_I, VPN_W'(1), PRIV_U, 1'b0, "clear");
    clear_tlbs();
    translate(SIDE_D, VPN_W'(1), PRIV_U, 1'b0, "clear");
    translate(SIDE_I, VPN_W'(1), PRIV_U, 1'b0, "clear");
    clear_tlbs();
    abort_req(SIDE_I, VPN_W'(2), "abort");
    translate(SIDE_I, VPN_W'(2), PRIV_U, 1'b0, "abort");
    abort_req(SIDE_D, VPN_W'(3), "abort");
    translate(SIDE_D, VPN_W'(3), PRIV_U, 1'b1, "abort");
    translate(SIDE_D, VPN_W'(0), PRIV_U, 1'b0, "abort");

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

/* build.f */
rtl/mmu_cfg_pkg.sv
rtl/mmu_xlat_pkg.sv
rtl/mmu_utlb.sv
rtl/mmu_utlb_arb.sv
rtl/mmu_jtlb.sv
rtl/mmu_utlb_top.sv
bench/tb_mmu_utlb_top.sv

/* Makefile */
SRCS := $(shell grep -v '^+' build.f)
BIN  := obj_dir/Vtb_mmu_utlb_top

.PHONY: all run clean

all: run

$(BIN): build.f $(SRCS)
	verilator --binary --timing --assert -f build.f --top-module tb_mmu_utlb_top -Mdir obj_dir

run: $(BIN)
	$(BIN) | tee sim.log
	@grep -q "Finished with no errors" sim.log
	@! grep -q "Finished with errors" sim.log

clean:
	rm -rf obj_dir sim.log
